// File: all.f
+incdir+source
source/sar_switch_pkg.sv
source/sar_control_pkg.sv
source/sar_sequencer.sv
source/cap_switch_driver.sv
source/offset_trim_search.sv
source/sar_adc_ctrl.sv
verif/sar_comparator_model.sv
verif/sar_adc_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the SAR ADC control testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
  --top-module sar_adc_ctrl_tb \
  -f all.f

./obj_dir/Vsar_adc_ctrl_tb | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "run_sim.sh: simulation reported a failure"
  exit 1
fi

echo "run_sim.sh: simulation finished without failures"
exit 0

// File: source/cap_switch_driver.sv
/* Capacitor DAC switch driver */

`timescale 1ns/1ps

`include "sar_consts.svh"

module cap_switch_driver
  import sar_switch_pkg::*;
  import sar_control_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 comp_result,
  input  dac_cmd_t             cmd,
  output dac_switch_t          dac,
  output logic [`SAR_BITS-1:0] result_code
);

  localparam plate_pair_t pair_high = '{top: PLATE_VDD, bot: PLATE_VSS};
  localparam plate_pair_t pair_low  = '{top: PLATE_VSS, bot: PLATE_VDD};

  // Precharge on, every plate back on the analog input.
  localparam dac_switch_t bank_released = {1'b1, {(4 * (`SAR_BITS + 1)){1'b0}}};

  dac_switch_t dac_next;

  always_comb begin
    dac_next = dac;
    case (cmd.mode)
      DAC_SAMPLE: begin
        dac_next           = bank_released;
        dac_next.precharge = 1'b0;
      end

      // Trial on the MSB, everything below it pulled the other way.
      DAC_FIRST_TRIAL: begin
        dac_next.precharge = 1'b0;
        dac_next.dummy     = pair_low;
        for (int i = 0; i < `SAR_BITS; i++) begin
          dac_next.plates[i] = pair_low;
        end
        dac_next.plates[`SAR_BITS-1] = pair_high;
      end

      DAC_DECIDE: begin
        dac_next.precharge                = 1'b0;
        dac_next.plates[cmd.bit_index]    = comp_result ? pair_high : pair_low;
        // The next lower plate becomes the new trial.
        if (cmd.bit_index != '0) begin
          dac_next.plates[cmd.bit_index - 1'b1] = pair_high;
        end
      end

      DAC_CALIBRATE: begin
        dac_next.precharge = 1'b1;
        dac_next.dummy     = pair_high;
        for (int i = 0; i < `SAR_BITS; i++) begin
          dac_next.plates[i] = pair_high;
        end
      end

      default: dac_next = bank_released;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dac <= bank_released;
    end else begin
      dac <= dac_next;
    end
  end

  // A plate left on VSS at its top means that bit was kept.
  always_comb begin
    result_code[0] = ~comp_result;
    for (int i = 1; i < `SAR_BITS; i++) begin
      result_code[i] = dac.plates[i].top[0];
    end
  end

endmodule

// File: source/offset_trim_search.sv
/* Comparator offset trim search */

`timescale 1ns/1ps

`include "sar_consts.svh"

module offset_trim_search
  import sar_control_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       cal_start,
  input  logic       comp_result,
  output logic       cal_done,
  output trim_code_t trim
);

  localparam logic [`TRIM_BITS-1:0] trim_full = '1;

  typedef enum logic [2:0] {
    TS_IDLE,
    TS_CLEAR0,
    TS_CLEAR1,
    TS_SENSE,
    TS_RAMP_UP,
    TS_RAMP_DOWN,
    TS_DONE
  } ts_state_t;

  ts_state_t             state;
  ts_state_t             state_next;
  logic                  off_bit;
  logic                  off_bit_next;
  trim_code_t            trim_next;
  trim_code_t            turn;
  trim_code_t            turn_next;
  logic [`TRIM_BITS-1:0] active;
  logic [`TRIM_BITS:0]   sum_cn;
  logic [`TRIM_BITS:0]   sum_cp;

  // The side that corrects the offset depends on the sensed polarity.
  assign active = off_bit ? trim.cn : trim.cp;

  assign sum_cn = {1'b0, turn.cn} + {1'b0, trim.cn};
  assign sum_cp = {1'b0, turn.cp} + {1'b0, trim.cp};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= TS_IDLE;
      off_bit <= 1'b0;
      turn    <= '0;
      trim    <= '0;
    end else begin
      state   <= state_next;
      off_bit <= off_bit_next;
      turn    <= turn_next;
      trim    <= trim_next;
    end
  end

  always_comb begin
    state_next   = state;
    off_bit_next = off_bit;
    turn_next    = turn;
    trim_next    = trim;
    cal_done     = 1'b0;

    case (state)
      TS_IDLE: if (cal_start) state_next = TS_CLEAR0;

      // Two settling cycles with no trim applied.
      TS_CLEAR0: begin
        trim_next  = '0;
        state_next = TS_CLEAR1;
      end

      TS_CLEAR1: begin
        trim_next  = '0;
        state_next = TS_SENSE;
      end

      TS_SENSE: begin
        off_bit_next = comp_result;
        state_next   = TS_RAMP_UP;
      end

      TS_RAMP_UP: begin
        if ((comp_result != off_bit) || (active == trim_full)) begin
          // First turning point found; restart from full scale on the same side.
          turn_next    = trim;
          trim_next.cn = {`TRIM_BITS{off_bit}};
          trim_next.cp = {`TRIM_BITS{~off_bit}};
          state_next   = TS_RAMP_DOWN;
        end else if (off_bit) begin
          trim_next.cn = trim.cn + 1'b1;
        end else begin
          trim_next.cp = trim.cp + 1'b1;
        end
      end

      TS_RAMP_DOWN: begin
        if ((comp_result == off_bit) || (active == '0)) begin
          // Settle halfway between the two turning points, rounded down.
          trim_next.cn = sum_cn[`TRIM_BITS:1];
          trim_next.cp = sum_cp[`TRIM_BITS:1];
          state_next   = TS_DONE;
        end else if (off_bit) begin
          trim_next.cn = trim.cn - 1'b1;
        end else begin
          trim_next.cp = trim.cp - 1'b1;
        end
      end

      TS_DONE: begin
        cal_done   = 1'b1;
        state_next = TS_IDLE;
      end

      default: state_next = TS_IDLE;
    endcase
  end

endmodule

// File: source/sar_adc_ctrl.sv
/* SAR ADC control top level */

`timescale 1ns/1ps

`include "sar_consts.svh"

module sar_adc_ctrl
  import sar_switch_pkg::*;
  import sar_control_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 adc_en,
  input  logic                 calib_en,
  input  logic                 comp_result,
  output dac_switch_t          dac,
  output logic                 eoc_n,
  output logic                 load_reg,
  output logic [`SAR_BITS-1:0] result_code,
  output trim_code_t           trim
);

  dac_cmd_t cmd;
  logic     cal_start;
  logic     cal_done;

  // The sequencer decides what the DAC does in each cycle.
  sar_sequencer u_sequencer (
    .clk       (clk),
    .rst       (rst),
    .adc_en    (adc_en),
    .calib_en  (calib_en),
    .cal_done  (cal_done),
    .cmd       (cmd),
    .cal_start (cal_start),
    .eoc_n     (eoc_n),
    .load_reg  (load_reg)
  );

  // Switch bank register and result assembly.
  cap_switch_driver u_switch_driver (
    .clk         (clk),
    .rst         (rst),
    .comp_result (comp_result),
    .cmd         (cmd),
    .dac         (dac),
    .result_code (result_code)
  );

  // Offset search runs only while the sequencer sits in calibration.
  offset_trim_search u_trim_search (
    .clk         (clk),
    .rst         (rst),
    .cal_start   (cal_start),
    .comp_result (comp_result),
    .cal_done    (cal_done),
    .trim        (trim)
  );

endmodule

// File: source/sar_consts.svh
/* SAR ADC converter constants */

`ifndef SAR_CONSTS_SVH
`define SAR_CONSTS_SVH

// Resolution of the converter in bits.
`define SAR_BITS 8

// Width of one comparator trim code.
// There is one code each for the n side and the p side.
`define TRIM_BITS 4

`endif

// File: source/sar_control_pkg.sv
/* SAR controller command types */

`include "sar_consts.svh"

package sar_control_pkg;

  // Operation that the switch driver applies at the next edge.
  typedef enum logic [2:0] {
    DAC_RELEASE,
    DAC_SAMPLE,
    DAC_FIRST_TRIAL,
    DAC_DECIDE,
    DAC_CALIBRATE
  } dac_mode_t;

  // bit_index names the plate decided by DAC_DECIDE.
  typedef struct packed {
    dac_mode_t                      mode;
    logic [$clog2(`SAR_BITS)-1:0]   bit_index;
  } dac_cmd_t;

  // Comparator offset trim for both inputs.
  typedef struct packed {
    logic [`TRIM_BITS-1:0] cn;
    logic [`TRIM_BITS-1:0] cp;
  } trim_code_t;

endpackage

// File: source/sar_sequencer.sv
/* SAR conversion sequencer */

`timescale 1ns/1ps

`include "sar_consts.svh"

module sar_sequencer
  import sar_control_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     adc_en,
  input  logic     calib_en,
  input  logic     cal_done,
  output dac_cmd_t cmd,
  output logic     cal_start,
  output logic     eoc_n,
  output logic     load_reg
);

  localparam int unsigned idx_w = $clog2(`SAR_BITS);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FIRST_TRIAL,
    ST_DECIDE,
    ST_FINISH,
    ST_CALIBRATE
  } seq_state_t;

  seq_state_t       state;
  seq_state_t       state_next;
  logic [idx_w-1:0] bit_cnt;
  logic [idx_w-1:0] bit_cnt_next;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= ST_IDLE;
      bit_cnt <= '0;
    end else begin
      state   <= state_next;
      bit_cnt <= bit_cnt_next;
    end
  end

  always_comb begin
    state_next    = state;
    bit_cnt_next  = bit_cnt;
    cmd.mode      = DAC_RELEASE;
    cmd.bit_index = bit_cnt;
    cal_start     = 1'b0;
    eoc_n         = 1'b0;
    load_reg      = 1'b0;

    case (state)
      ST_IDLE: begin
        // Calibration wins when both requests are present.
        if (calib_en) begin
          cal_start  = 1'b1;
          state_next = ST_CALIBRATE;
        end else if (adc_en) begin
          cmd.mode   = DAC_SAMPLE;
          state_next = ST_FIRST_TRIAL;
        end
      end

      ST_FIRST_TRIAL: begin
        eoc_n        = 1'b1;
        cmd.mode     = DAC_FIRST_TRIAL;
        bit_cnt_next = idx_w'(`SAR_BITS - 1);
        state_next   = ST_DECIDE;
      end

      ST_DECIDE: begin
        eoc_n    = 1'b1;
        cmd.mode = DAC_DECIDE;
        // Bit 0 is resolved in the finish cycle, straight from the comparator.
        if (bit_cnt == 1) begin
          state_next = ST_FINISH;
        end else begin
          bit_cnt_next = bit_cnt - 1'b1;
        end
      end

      ST_FINISH: begin
        eoc_n      = 1'b1;
        load_reg   = 1'b1;
        state_next = ST_IDLE;
      end

      ST_CALIBRATE: begin
        if (cal_done) begin
          state_next = ST_IDLE;
        end else begin
          cmd.mode = DAC_CALIBRATE;
        end
      end

      default: state_next = ST_IDLE;
    endcase
  end

endmodule

// File: source/sar_switch_pkg.sv
/* Capacitor DAC switch network types */

`include "sar_consts.svh"

package sar_switch_pkg;

  // Position of one plate switch.
  // The bit patterns are one-hot for the two supply connections.
  typedef enum logic [1:0] {
    PLATE_INPUT = 2'b00,
    PLATE_VSS   = 2'b01,
    PLATE_VDD   = 2'b10
  } plate_sw_t;

  // Top and bottom switch of one differential capacitor.
  typedef struct packed {
    plate_sw_t top;
    plate_sw_t bot;
  } plate_pair_t;

  // Complete switch bank of the capacitor DAC.
  // When precharge is set, the capacitor tops are tied to mid-supply.
  // Index SAR_BITS-1 of plates is the MSB capacitor.
  typedef struct packed {
    logic                           precharge;
    plate_pair_t                    dummy;
    plate_pair_t [`SAR_BITS-1:0]    plates;
  } dac_switch_t;

endpackage

// File: verif/sar_adc_ctrl_tb.sv
/* SAR ADC control testbench */

`timescale 1ns/1ps

`include "sar_consts.svh"

module sar_adc_ctrl_tb
  import sar_switch_pkg::*;
  import sar_control_pkg::*;
();

  localparam int row_count   = 18;
  localparam int cycle_limit = 60 * row_count + 20;
  localparam int busy_cycles = `SAR_BITS + 1;
  localparam int conv_period = `SAR_BITS + 2;
  localparam int cal_cycles  = 40;

  typedef logic [`SAR_BITS-1:0] code_t;

  typedef enum logic [1:0] {
    ROW_CONVERT,
    ROW_BACK_TO_BACK,
    ROW_CALIBRATE,
    ROW_PRIORITY
  } row_mode_t;

  typedef struct packed {
    row_mode_t             mode;
    code_t                 code;
    logic                  sign;
    logic [`TRIM_BITS-1:0] threshold;
    code_t                 exp_code;
    trim_code_t            exp_trim;
  } test_row_t;

  test_row_t             rows [row_count];
  logic                  clk;
  logic                  rst;
  logic                  adc_en;
  logic                  calib_en;
  logic                  comp_result;
  dac_switch_t           dac;
  logic                  eoc_n;
  logic                  load_reg;
  code_t                 result_code;
  trim_code_t            trim;
  code_t                 sample_code;
  logic                  cal_sign;
  logic [`TRIM_BITS-1:0] cal_threshold;
  integer                seed;
  int                    error_cnt;
  int                    rows_run;
  int                    cycle_cnt = 0;

  sar_adc_ctrl DUT (
    .clk         (clk),
    .rst         (rst),
    .adc_en      (adc_en),
    .calib_en    (calib_en),
    .comp_result (comp_result),
    .dac         (dac),
    .eoc_n       (eoc_n),
    .load_reg    (load_reg),
    .result_code (result_code),
    .trim        (trim)
  );

  sar_comparator_model comparator (
    .clk         (clk),
    .rst         (rst),
    .eoc_n       (eoc_n),
    .trim        (trim),
    .sample_code (sample_code),
    .sign        (cal_sign),
    .threshold   (cal_threshold),
    .comp_result (comp_result)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    if (cycle_cnt >= cycle_limit) begin
      $display("Run stopped: the tests did not finish within %0d cycles.", cycle_limit);
      $display("Simulation FAILED");
      $finish;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  task automatic flag_error(input string msg);
    error_cnt++;
    $display("error at %0d ns: %s", $time, msg);
  endtask

  function automatic logic plates_on_input(input dac_switch_t bank);
    logic ok;
    ok = (bank.dummy.top == PLATE_INPUT) && (bank.dummy.bot == PLATE_INPUT);
    for (int i = 0; i < `SAR_BITS; i++) begin
      if ((bank.plates[i].top != PLATE_INPUT) || (bank.plates[i].bot != PLATE_INPUT)) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  // MSB pulled up, every lower plate and the dummy pulled the other way.
  function automatic logic first_trial_ok(input dac_switch_t bank);
    logic ok;
    ok = (bank.dummy.top == PLATE_VSS) && (bank.dummy.bot == PLATE_VDD);
    for (int i = 0; i < `SAR_BITS - 1; i++) begin
      if ((bank.plates[i].top != PLATE_VSS) || (bank.plates[i].bot != PLATE_VDD)) begin
        ok = 1'b0;
      end
    end
    if ((bank.plates[`SAR_BITS-1].top != PLATE_VDD) ||
        (bank.plates[`SAR_BITS-1].bot != PLATE_VSS)) begin
      ok = 1'b0;
    end
    return ok;
  endfunction

  function automatic test_row_t conv_row(input row_mode_t mode, input code_t code);
    test_row_t row;
    row          = '0;
    row.mode     = mode;
    row.code     = code;
    row.exp_code = code;
    return row;
  endfunction

  function automatic test_row_t cal_row(input row_mode_t mode, input logic sgn,
                                        input logic [`TRIM_BITS-1:0] thr);
    test_row_t row;
    row           = '0;
    row.mode      = mode;
    row.sign      = sgn;
    row.threshold = thr;
    // The search settles one step below the trim where the comparator flips.
    if (sgn) begin
      row.exp_trim.cn = thr - 1'b1;
    end else begin
      row.exp_trim.cp = thr - 1'b1;
    end
    return row;
  endfunction

  task automatic fill_table;
    rows[0]  = conv_row(ROW_CONVERT, 8'h00);
    rows[1]  = conv_row(ROW_CONVERT, 8'hff);
    rows[2]  = conv_row(ROW_CONVERT, 8'h80);
    rows[3]  = conv_row(ROW_CONVERT, 8'h7f);
    rows[4]  = conv_row(ROW_CONVERT, 8'h55);
    for (int r = 5; r < 9; r++) begin
      rows[r] = conv_row(ROW_CONVERT, code_t'($random(seed)));
    end
    rows[9]  = conv_row(ROW_BACK_TO_BACK, code_t'($random(seed)));
    rows[10] = cal_row(ROW_CALIBRATE, 1'b1, 4'd1);
    rows[11] = cal_row(ROW_CALIBRATE, 1'b1, 4'd7);
    rows[12] = cal_row(ROW_CALIBRATE, 1'b1, 4'd15);
    rows[13] = cal_row(ROW_CALIBRATE, 1'b0, 4'd1);
    rows[14] = cal_row(ROW_CALIBRATE, 1'b0, 4'd9);
    rows[15] = cal_row(ROW_CALIBRATE, 1'b0, 4'd15);
    rows[16] = cal_row(ROW_PRIORITY, 1'b1, 4'd5);
    rows[17] = conv_row(ROW_CONVERT, code_t'($random(seed)));
  endtask

  // Follows one busy window from its first cycle to the first idle cycle after it.
  task automatic watch_conversion(input code_t exp_code, input logic drop_en,
                                  output int start_cycle);
    int busy;
    int loads;
    int waited;
    busy        = 0;
    loads       = 0;
    waited      = 0;
    start_cycle = 0;
    @(negedge clk);
    while (!eoc_n && (waited < conv_period)) begin
      waited++;
      @(negedge clk);
    end
    if (!eoc_n) begin
      flag_error("no busy window started after adc_en");
      return;
    end
    start_cycle = cycle_cnt;
    while (eoc_n && (busy < 2 * busy_cycles)) begin
      busy++;
      if ((busy == 1) && (dac.precharge || !plates_on_input(dac))) begin
        flag_error("switches do not show the sample pattern in busy cycle 1");
      end
      // The first-trial pattern is registered at the end of busy cycle 1.
      if ((busy == 2) && !first_trial_ok(dac)) begin
        flag_error("switches do not show the first-trial pattern");
      end
      if (load_reg) begin
        loads++;
        if (busy != busy_cycles) begin
          flag_error($sformatf("load_reg high in busy cycle %0d", busy));
        end
        if (result_code != exp_code) begin
          flag_error($sformatf("result_code %h, expected %h", result_code, exp_code));
        end
      end
      if ((busy == 1) && drop_en) begin
        @(posedge clk);
        adc_en <= 1'b0;
      end
      @(negedge clk);
    end
    if (busy != busy_cycles) begin
      flag_error($sformatf("busy window lasted %0d cycles", busy));
    end
    if (loads != 1) begin
      flag_error($sformatf("load_reg pulsed %0d times in one window", loads));
    end
    if (!dac.precharge || !plates_on_input(dac)) begin
      flag_error("switches not released after the busy window");
    end
  endtask

  task automatic run_conversion(input test_row_t row);
    int start_a;
    int start_b;
    @(posedge clk);
    sample_code <= row.code;
    adc_en      <= 1'b1;
    if (row.mode == ROW_BACK_TO_BACK) begin
      watch_conversion(row.exp_code, 1'b0, start_a);
      watch_conversion(row.exp_code, 1'b1, start_b);
      if (start_b - start_a != conv_period) begin
        flag_error($sformatf("second window began %0d cycles after the first",
                             start_b - start_a));
      end
    end else begin
      watch_conversion(row.exp_code, 1'b1, start_a);
    end
  endtask

  task automatic run_calibration(input test_row_t row);
    @(posedge clk);
    cal_sign      <= row.sign;
    cal_threshold <= row.threshold;
    calib_en      <= 1'b1;
    adc_en        <= (row.mode == ROW_PRIORITY);
    @(posedge clk);
    calib_en <= 1'b0;
    adc_en   <= 1'b0;
    for (int n = 0; n < cal_cycles; n++) begin
      @(negedge clk);
      if (eoc_n || load_reg) begin
        flag_error("busy window or load_reg seen during calibration");
      end
      if (!dac.precharge) begin
        flag_error("precharge dropped during calibration");
      end
    end
    if (trim != row.exp_trim) begin
      flag_error($sformatf("trim cn %0d cp %0d, expected cn %0d cp %0d",
                           trim.cn, trim.cp, row.exp_trim.cn, row.exp_trim.cp));
    end
  endtask

  initial begin
    seed          = 32'h0294_7c4f;
    error_cnt     = 0;
    rows_run      = 0;
    rst           = 1'b1;
    adc_en        = 1'b0;
    calib_en      = 1'b0;
    sample_code   = '0;
    cal_sign      = 1'b0;
    cal_threshold = 4'd1;
    fill_table();

    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (eoc_n || load_reg || !dac.precharge || !plates_on_input(dac) || (trim != '0)) begin
      flag_error("outputs not in their reset state");
    end

    for (int r = 0; r < row_count; r++) begin
      case (rows[r].mode)
        ROW_CONVERT:      run_conversion(rows[r]);
        ROW_BACK_TO_BACK: run_conversion(rows[r]);
        ROW_CALIBRATE:    run_calibration(rows[r]);
        ROW_PRIORITY:     run_calibration(rows[r]);
      endcase
      rows_run++;
    end

    repeat (2) @(posedge clk);
    $display("Rows run: %0d, errors: %0d", rows_run, error_cnt);
    if (error_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: verif/sar_comparator_model.sv
/* Behavioral SAR comparator */

`timescale 1ns/1ps

`include "sar_consts.svh"

module sar_comparator_model
  import sar_control_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  eoc_n,
  input  trim_code_t            trim,
  input  logic [`SAR_BITS-1:0]  sample_code,
  input  logic                  sign,
  input  logic [`TRIM_BITS-1:0] threshold,
  output logic                  comp_result
);

  localparam int idx_w = $clog2(`SAR_BITS);

  // Busy cycles already completed in the current window.
  int                    done_cycles;
  logic [`SAR_BITS-1:0]  decided;
  logic [`SAR_BITS-1:0]  trial;
  logic [idx_w-1:0]      tested_bit;
  logic [`TRIM_BITS-1:0] correcting;
  logic                  in_decision;

  always_comb begin
    in_decision = eoc_n && (done_cycles >= 1) && (done_cycles <= `SAR_BITS);
    tested_bit  = idx_w'(`SAR_BITS - done_cycles);
    trial       = decided;
    if (in_decision) begin
      trial[tested_bit] = 1'b1;
    end
    correcting = sign ? trim.cn : trim.cp;
    // A zero answer keeps the tested bit.
    if (in_decision) begin
      comp_result = (sample_code >= trial) ? 1'b0 : 1'b1;
    end else begin
      comp_result = (correcting < threshold) ? sign : ~sign;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      done_cycles <= 0;
      decided     <= '0;
    end else if (!eoc_n) begin
      done_cycles <= 0;
      decided     <= '0;
    end else begin
      done_cycles <= done_cycles + 1;
      if (in_decision && !comp_result) begin
        decided[tested_bit] <= 1'b1;
      end
    end
  end

endmodule
